//--- logic/cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

  localparam int unsigned addr_w    = 5;
  localparam int unsigned tag_w     = 3;
  localparam int unsigned index_w   = 2;
  localparam int unsigned data_w    = 3;

  localparam int unsigned num_sets  = 1 << index_w;  // 4 sets
  localparam int unsigned num_ways  = 2;
  localparam int unsigned mem_words = 1 << addr_w;   // full 5-bit address space

  // address layout is {tag, index}
  typedef logic [addr_w-1:0]  addr_t;
  typedef logic [tag_w-1:0]   tag_t;    // upper address bits
  typedef logic [index_w-1:0] index_t;  // lower address bits
  typedef logic [data_w-1:0]  data_t;
  typedef logic               way_t;    // one bit for two ways

endpackage

`default_nettype wire

//--- logic/cache_fsm_pkg.sv
`default_nettype none

package cache_fsm_pkg;

  typedef enum logic [1:0] {
    st_idle,       // lookup happens here
    st_writeback,  // dirty victim going out
    st_read_mem,   // refill read issued
    st_fill        // line write and response
  } ctrl_state_t;

  // edges from request sample to resp_valid
  localparam int unsigned hit_latency        = 1;
  localparam int unsigned clean_miss_latency = 3;
  localparam int unsigned dirty_miss_latency = 4;

endpackage

`default_nettype wire

//--- logic/cache_array.sv
`default_nettype none

module cache_array (
  input  logic                  clock,
  input  logic                  rst_n,
  input  cache_geom_pkg::index_t lookup_index,
  input  cache_geom_pkg::tag_t   lookup_tag,
  input  logic                  line_we,
  input  cache_geom_pkg::way_t   line_way,
  input  cache_geom_pkg::tag_t   line_tag,
  input  cache_geom_pkg::data_t  line_data,
  input  logic                  line_dirty,
  output logic                  lookup_hit,
  output cache_geom_pkg::way_t   hit_way,
  output cache_geom_pkg::data_t  hit_data,
  output cache_geom_pkg::way_t   victim_way,
  output logic                  victim_dirty,
  output cache_geom_pkg::tag_t   victim_tag,
  output cache_geom_pkg::data_t  victim_data
);

  // line state, indexed [way][set]
  logic                  valid_q [cache_geom_pkg::num_ways][cache_geom_pkg::num_sets];
  logic                  dirty_q [cache_geom_pkg::num_ways][cache_geom_pkg::num_sets];
  cache_geom_pkg::tag_t  tag_q   [cache_geom_pkg::num_ways][cache_geom_pkg::num_sets];
  cache_geom_pkg::data_t data_q  [cache_geom_pkg::num_ways][cache_geom_pkg::num_sets];

  cache_geom_pkg::way_t  lru_q [cache_geom_pkg::num_sets];  // way to evict next

  logic [cache_geom_pkg::num_ways-1:0] way_hit;
  logic                                keep_dirty;

  // tag compare against every way of the set
  always_comb begin
    for (int w = 0; w < cache_geom_pkg::num_ways; w++) begin
      way_hit[w] = valid_q[w][lookup_index] && (tag_q[w][lookup_index] == lookup_tag);
    end
  end

  assign lookup_hit = |way_hit;
  assign hit_way    = way_hit[1];
  assign hit_data   = data_q[hit_way][lookup_index];

  // an empty way is always taken before the lru one
  always_comb begin
    if (!valid_q[0][lookup_index]) begin
      victim_way = 1'b0;
    end else if (!valid_q[1][lookup_index]) begin
      victim_way = 1'b1;
    end else begin
      victim_way = lru_q[lookup_index];
    end
  end

  assign victim_dirty = valid_q[victim_way][lookup_index] && dirty_q[victim_way][lookup_index];
  assign victim_tag   = tag_q[victim_way][lookup_index];
  assign victim_data  = data_q[victim_way][lookup_index];

  // a rewrite of the resident line (read hit) must not lose its dirty bit,
  // while a fill replaces a different tag and takes line_dirty as given
  assign keep_dirty = valid_q[line_way][lookup_index] && dirty_q[line_way][lookup_index]
                      && (tag_q[line_way][lookup_index] == line_tag);

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      for (int w = 0; w < cache_geom_pkg::num_ways; w++) begin
        for (int s = 0; s < cache_geom_pkg::num_sets; s++) begin
          valid_q[w][s] <= 1'b0;
          dirty_q[w][s] <= 1'b0;
        end
      end
      for (int s = 0; s < cache_geom_pkg::num_sets; s++) begin
        lru_q[s] <= 1'b0;  // all sets start pointing at way 0
      end
    end else if (line_we) begin
      valid_q[line_way][lookup_index] <= 1'b1;
      dirty_q[line_way][lookup_index] <= line_dirty | keep_dirty;
      lru_q[lookup_index]             <= ~line_way;  // written way becomes mru
    end
  end

  always_ff @(posedge clock) begin
    if (line_we) begin
      tag_q[line_way][lookup_index]  <= line_tag;
      data_q[line_way][lookup_index] <= line_data;
    end
  end

  // a second copy of a tag could only come from a fill that missed a live hit
  a_single_way_hit: assert property (
    @(posedge clock) disable iff (!rst_n)
    line_we |-> !(way_hit[0] && way_hit[1])
  ) else $error("cache_array: tag present in both ways of set %0d", lookup_index);

endmodule

`default_nettype wire

//--- logic/cache_ctrl.sv
`default_nettype none

module cache_ctrl (
  input  logic                   clock,
  input  logic                   rst_n,
  input  logic                   req_valid,
  input  logic                   req_write,
  input  cache_geom_pkg::addr_t  address,
  input  cache_geom_pkg::data_t  data,
  input  logic                   lookup_hit,
  input  cache_geom_pkg::way_t   hit_way,
  input  cache_geom_pkg::data_t  hit_data,
  input  cache_geom_pkg::way_t   victim_way,
  input  logic                   victim_dirty,
  input  cache_geom_pkg::tag_t   victim_tag,
  input  cache_geom_pkg::data_t  victim_data,
  input  cache_geom_pkg::data_t  mem_rdata,
  output cache_geom_pkg::index_t lookup_index,
  output cache_geom_pkg::tag_t   lookup_tag,
  output logic                   line_we,
  output cache_geom_pkg::way_t   line_way,
  output cache_geom_pkg::tag_t   line_tag,
  output cache_geom_pkg::data_t  line_data,
  output logic                   line_dirty,
  output cache_geom_pkg::addr_t  mem_address,
  output logic                   mem_we,
  output cache_geom_pkg::data_t  mem_wdata,
  output logic                   resp_valid,
  output cache_geom_pkg::data_t  q,
  output logic                   hit,
  output logic                   wb_valid,
  output cache_geom_pkg::addr_t  wb_address,
  output cache_geom_pkg::data_t  wb_data
);

  cache_fsm_pkg::ctrl_state_t state_q;

  cache_geom_pkg::addr_t req_addr_q;   // latched on a miss
  logic                  req_write_q;
  cache_geom_pkg::data_t req_data_q;
  cache_geom_pkg::way_t  fill_way_q;
  cache_geom_pkg::tag_t  wb_tag_q;
  cache_geom_pkg::data_t wb_data_q;

  cache_geom_pkg::addr_t lookup_addr;
  logic                  accept;

  assign accept      = req_valid && (state_q == cache_fsm_pkg::st_idle);
  assign lookup_addr = (state_q == cache_fsm_pkg::st_idle) ? address : req_addr_q;

  assign lookup_index = lookup_addr[cache_geom_pkg::index_w-1:0];
  assign lookup_tag   = lookup_addr[cache_geom_pkg::addr_w-1 -: cache_geom_pkg::tag_w];

  // single array write port, shared by hits and fills
  always_comb begin
    line_we    = 1'b0;
    line_way   = hit_way;
    line_tag   = lookup_tag;
    line_data  = hit_data;
    line_dirty = 1'b0;
    case (state_q)
      cache_fsm_pkg::st_idle: begin
        if (req_valid && lookup_hit) begin
          line_we    = 1'b1;  // read hit still refreshes lru
          line_data  = req_write ? data : hit_data;
          line_dirty = req_write;
        end
      end
      cache_fsm_pkg::st_fill: begin
        line_we    = 1'b1;
        line_way   = fill_way_q;
        line_data  = req_write_q ? req_data_q : mem_rdata;  // write-allocate
        line_dirty = req_write_q;
      end
      default: ;
    endcase
  end

  assign wb_valid   = (state_q == cache_fsm_pkg::st_writeback);
  assign wb_address = {wb_tag_q, req_addr_q[cache_geom_pkg::index_w-1:0]};
  assign wb_data    = wb_data_q;

  assign mem_we      = wb_valid;
  assign mem_address = wb_valid ? wb_address : req_addr_q;
  assign mem_wdata   = wb_data_q;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state_q    <= cache_fsm_pkg::st_idle;
      resp_valid <= 1'b0;
      hit        <= 1'b0;
    end else begin
      resp_valid <= 1'b0;
      case (state_q)
        cache_fsm_pkg::st_idle: begin
          if (req_valid) begin
            hit <= lookup_hit;
            if (lookup_hit) begin
              resp_valid <= 1'b1;  // hits answer on the next cycle
            end else if (victim_dirty) begin
              state_q <= cache_fsm_pkg::st_writeback;
            end else begin
              state_q <= cache_fsm_pkg::st_read_mem;
            end
          end
        end
        cache_fsm_pkg::st_writeback: state_q <= cache_fsm_pkg::st_read_mem;
        cache_fsm_pkg::st_read_mem:  state_q <= cache_fsm_pkg::st_fill;  // rdata valid next
        cache_fsm_pkg::st_fill: begin
          resp_valid <= 1'b1;
          state_q    <= cache_fsm_pkg::st_idle;
        end
        default: state_q <= cache_fsm_pkg::st_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      req_addr_q  <= address;
      req_write_q <= req_write;
      req_data_q  <= data;
      fill_way_q  <= victim_way;
      wb_tag_q    <= victim_tag;
      wb_data_q   <= victim_data;
      q           <= req_write ? data : hit_data;
    end else if (state_q == cache_fsm_pkg::st_fill) begin
      q <= line_data;
    end
  end

  a_resp_pulse: assert property (
    @(posedge clock) disable iff (!rst_n)
    resp_valid |=> !resp_valid
  ) else $error("cache_ctrl: resp_valid held longer than one cycle");

  // victim holds another tag, so the writeback never lands on the refill address
  a_wb_other_line: assert property (
    @(posedge clock) disable iff (!rst_n)
    wb_valid |-> (wb_address != req_addr_q)
  ) else $error("cache_ctrl: writeback targets the address being refilled");

  a_req_when_idle: assert property (
    @(posedge clock) disable iff (!rst_n)
    req_valid |-> (state_q == cache_fsm_pkg::st_idle)
  ) else $error("cache_ctrl: request issued while a miss is in flight");

endmodule

`default_nettype wire

//--- logic/main_mem.sv
`default_nettype none

module main_mem (
  input  logic                  clock,
  input  cache_geom_pkg::addr_t mem_address,
  input  logic                  mem_we,
  input  cache_geom_pkg::data_t mem_wdata,
  output cache_geom_pkg::data_t mem_rdata
);

  cache_geom_pkg::data_t mem_q [cache_geom_pkg::mem_words];  // whole address space

  // write and read share the address, read returns the old word
  always_ff @(posedge clock) begin
    if (mem_we) begin
      mem_q[mem_address] <= mem_wdata;
    end
    mem_rdata <= mem_q[mem_address];  // one cycle read latency
  end

endmodule

`default_nettype wire

//--- logic/cache_2way.sv
`default_nettype none

module cache_2way (
  input  logic                  clock,
  input  logic                  rst_n,
  input  logic                  req_valid,
  input  logic                  req_write,
  input  cache_geom_pkg::addr_t address,
  input  cache_geom_pkg::data_t data,
  output logic                  resp_valid,
  output cache_geom_pkg::data_t q,
  output logic                  hit,
  output logic                  wb_valid,
  output cache_geom_pkg::addr_t wb_address,
  output cache_geom_pkg::data_t wb_data
);

  // lookup side
  cache_geom_pkg::index_t lookup_index;
  cache_geom_pkg::tag_t   lookup_tag;
  logic                   lookup_hit;
  cache_geom_pkg::way_t   hit_way;
  cache_geom_pkg::data_t  hit_data;
  cache_geom_pkg::way_t   victim_way;
  logic                   victim_dirty;
  cache_geom_pkg::tag_t   victim_tag;
  cache_geom_pkg::data_t  victim_data;

  // array write port
  logic                   line_we;
  cache_geom_pkg::way_t   line_way;
  cache_geom_pkg::tag_t   line_tag;
  cache_geom_pkg::data_t  line_data;
  logic                   line_dirty;

  // backing memory port
  cache_geom_pkg::addr_t  mem_address;
  logic                   mem_we;
  cache_geom_pkg::data_t  mem_wdata;
  cache_geom_pkg::data_t  mem_rdata;

  cache_ctrl ctrl (
    .clock, .rst_n, .req_valid, .req_write, .address, .data,
    .lookup_hit, .hit_way, .hit_data,
    .victim_way, .victim_dirty, .victim_tag, .victim_data,
    .mem_rdata,
    .lookup_index, .lookup_tag,
    .line_we, .line_way, .line_tag, .line_data, .line_dirty,
    .mem_address, .mem_we, .mem_wdata,
    .resp_valid, .q, .hit,
    .wb_valid, .wb_address, .wb_data
  );

  cache_array array (
    .clock, .rst_n, .lookup_index, .lookup_tag,
    .line_we, .line_way, .line_tag, .line_data, .line_dirty,
    .lookup_hit, .hit_way, .hit_data,
    .victim_way, .victim_dirty, .victim_tag, .victim_data
  );

  main_mem mem (
    .clock, .mem_address, .mem_we, .mem_wdata, .mem_rdata
  );

endmodule

`default_nettype wire

//--- dv/cache_2way_tb.sv
`default_nettype none

module cache_2way_tb;
  timeunit 1ns;
  timeprecision 1ns;

  localparam int unsigned period      = 100;
  localparam int unsigned reset_len   = 4;
  localparam int unsigned num_random  = 200;
  localparam int unsigned num_request = num_random + 6;  // directed ones included
  localparam int unsigned resp_limit  = 2 * cache_fsm_pkg::dirty_miss_latency;
  localparam int unsigned watchdog_cycles =
    num_request * (cache_fsm_pkg::dirty_miss_latency + 1) + reset_len + 40;

  logic                  clock = 1'b0;
  logic                  rst_n;
  logic                  req_valid;
  logic                  req_write;
  cache_geom_pkg::addr_t address;
  cache_geom_pkg::data_t data;
  logic                  resp_valid;
  cache_geom_pkg::data_t q;
  logic                  hit;
  logic                  wb_valid;
  cache_geom_pkg::addr_t wb_address;
  cache_geom_pkg::data_t wb_data;

  // reference model of the cache lines and the backing memory
  logic                  m_valid [cache_geom_pkg::num_ways][cache_geom_pkg::num_sets];
  logic                  m_dirty [cache_geom_pkg::num_ways][cache_geom_pkg::num_sets];
  logic                  m_known [cache_geom_pkg::num_ways][cache_geom_pkg::num_sets];
  cache_geom_pkg::tag_t  m_tag   [cache_geom_pkg::num_ways][cache_geom_pkg::num_sets];
  cache_geom_pkg::data_t m_data  [cache_geom_pkg::num_ways][cache_geom_pkg::num_sets];
  cache_geom_pkg::way_t  m_lru   [cache_geom_pkg::num_sets];
  cache_geom_pkg::data_t mem_data  [cache_geom_pkg::mem_words];
  logic                  mem_known [cache_geom_pkg::mem_words];

  // expectations for the request in flight
  logic                  exp_hit;
  cache_geom_pkg::data_t exp_q;
  logic                  exp_q_known;
  int unsigned           exp_lat;
  logic                  exp_wb;
  cache_geom_pkg::addr_t exp_wb_addr;
  cache_geom_pkg::data_t exp_wb_data;

  int unsigned cycles       = 0;
  logic        wb_seen      = 1'b0;
  int unsigned check_errors = 0;
  int unsigned flow_errors  = 0;
  int unsigned req_count    = 0;
  int unsigned tests_done   = 0;
  int unsigned errors_mark  = 0;
  integer      seed;
  logic [31:0] rnd;

  always #(period / 2) clock = ~clock;

  cache_2way uut (
    .clock, .rst_n, .req_valid, .req_write, .address, .data,
    .resp_valid, .q, .hit, .wb_valid, .wb_address, .wb_data
  );

  // edges since the request was sampled
  always @(posedge clock) begin
    if (req_valid) begin
      cycles <= 1;
    end else if (!resp_valid) begin
      cycles <= cycles + 1;
    end
  end

  always @(posedge clock) begin
    if (req_valid) begin
      wb_seen <= 1'b0;
    end else if (wb_valid) begin
      wb_seen <= 1'b1;
    end
  end

  check_hit: assert property (@(posedge clock) disable iff (!rst_n)
    resp_valid |-> hit == exp_hit)
  else begin
    check_errors++;
    $display("Error: %0t ns, signal hit, expected %0b, got %0b",
             $time, $sampled(exp_hit), $sampled(hit));
  end

  check_q: assert property (@(posedge clock) disable iff (!rst_n)
    resp_valid && exp_q_known |-> q == exp_q)
  else begin
    check_errors++;
    $display("Error: %0t ns, signal q, expected %0d, got %0d",
             $time, $sampled(exp_q), $sampled(q));
  end

  check_latency: assert property (@(posedge clock) disable iff (!rst_n)
    resp_valid |-> cycles == exp_lat)
  else begin
    check_errors++;
    $display("Error: %0t ns, signal resp_valid latency, expected %0d, got %0d",
             $time, $sampled(exp_lat), $sampled(cycles));
  end

  check_wb_expected: assert property (@(posedge clock) disable iff (!rst_n)
    wb_valid |-> exp_wb && !wb_seen)
  else begin
    check_errors++;
    $display("Error: %0t ns, signal wb_valid, expected 0, got 1", $time);
  end

  check_wb_address: assert property (@(posedge clock) disable iff (!rst_n)
    wb_valid && exp_wb |-> wb_address == exp_wb_addr)
  else begin
    check_errors++;
    $display("Error: %0t ns, signal wb_address, expected %0d, got %0d",
             $time, $sampled(exp_wb_addr), $sampled(wb_address));
  end

  check_wb_data: assert property (@(posedge clock) disable iff (!rst_n)
    wb_valid && exp_wb |-> wb_data == exp_wb_data)
  else begin
    check_errors++;
    $display("Error: %0t ns, signal wb_data, expected %0d, got %0d",
             $time, $sampled(exp_wb_data), $sampled(wb_data));
  end

  check_wb_missing: assert property (@(posedge clock) disable iff (!rst_n)
    resp_valid && exp_wb |-> wb_seen)
  else begin
    check_errors++;
    $display("Error: %0t ns, a dirty eviction answered without any wb_valid", $time);
  end

  // applies one request to the model and returns what the cache must do
  task automatic predict(input logic write, input cache_geom_pkg::addr_t addr,
                         input cache_geom_pkg::data_t wdata,
                         output logic p_hit, output cache_geom_pkg::data_t p_q,
                         output logic p_q_known, output int unsigned p_lat,
                         output logic p_wb, output cache_geom_pkg::addr_t p_wb_addr,
                         output cache_geom_pkg::data_t p_wb_data);
    cache_geom_pkg::index_t set;
    cache_geom_pkg::tag_t   tag;
    cache_geom_pkg::way_t   way;
    set       = addr[cache_geom_pkg::index_w-1:0];
    tag       = addr[cache_geom_pkg::addr_w-1 -: cache_geom_pkg::tag_w];
    p_hit     = 1'b1;
    p_wb      = 1'b0;
    p_wb_addr = '0;
    p_wb_data = '0;
    p_lat     = cache_fsm_pkg::hit_latency;
    if (m_valid[0][set] && m_tag[0][set] == tag) begin
      way = 1'b0;
    end else if (m_valid[1][set] && m_tag[1][set] == tag) begin
      way = 1'b1;
    end else begin
      p_hit = 1'b0;
      if (!m_valid[0][set]) begin
        way = 1'b0;  // empty ways go first
      end else if (!m_valid[1][set]) begin
        way = 1'b1;
      end else begin
        way = m_lru[set];
      end
      p_lat = cache_fsm_pkg::clean_miss_latency;
      if (m_valid[way][set] && m_dirty[way][set]) begin
        p_wb      = 1'b1;
        p_wb_addr = {m_tag[way][set], set};
        p_wb_data = m_data[way][set];
        mem_data[p_wb_addr]  = p_wb_data;
        mem_known[p_wb_addr] = 1'b1;
        p_lat = cache_fsm_pkg::dirty_miss_latency;
      end
      m_valid[way][set] = 1'b1;
      m_tag[way][set]   = tag;
      m_dirty[way][set] = 1'b0;
      m_data[way][set]  = mem_data[addr];  // refill
      m_known[way][set] = mem_known[addr];
    end
    if (write) begin
      m_data[way][set]  = wdata;
      m_known[way][set] = 1'b1;
      m_dirty[way][set] = 1'b1;
    end
    p_q       = m_data[way][set];
    p_q_known = m_known[way][set];
    m_lru[set] = ~way;
  endtask

  task automatic run_request(input logic write, input cache_geom_pkg::addr_t addr,
                             input cache_geom_pkg::data_t wdata);
    logic                  p_hit;
    cache_geom_pkg::data_t p_q;
    logic                  p_q_known;
    int unsigned           p_lat;
    logic                  p_wb;
    cache_geom_pkg::addr_t p_wb_addr;
    cache_geom_pkg::data_t p_wb_data;
    int unsigned           waited;
    predict(write, addr, wdata, p_hit, p_q, p_q_known, p_lat, p_wb, p_wb_addr, p_wb_data);
    req_valid   <= 1'b1;
    req_write   <= write;
    address     <= addr;
    data        <= wdata;
    exp_hit     <= p_hit;
    exp_q       <= p_q;
    exp_q_known <= p_q_known;
    exp_lat     <= p_lat;
    exp_wb      <= p_wb;
    exp_wb_addr <= p_wb_addr;
    exp_wb_data <= p_wb_data;
    req_count++;
    @(posedge clock);
    req_valid <= 1'b0;
    waited = 0;
    do begin
      @(posedge clock);
      waited++;
    end while (!resp_valid && waited < resp_limit);
    if (!resp_valid) begin
      flow_errors++;
      $display("no response within %0d cycles to the request for address %0d",
               resp_limit, addr);
    end
  endtask

  task automatic end_test(input string name);
    int unsigned errors_now;
    @(posedge clock);  // response checks of the last edge are done
    errors_now = check_errors + flow_errors;
    tests_done++;
    if (errors_now == errors_mark) begin
      $display("test %0d, %s: ok", tests_done, name);
    end else begin
      $display("test %0d, %s: %0d errors", tests_done, name, errors_now - errors_mark);
    end
    errors_mark = errors_now;
  endtask

  initial begin
    seed        = 32'h3fa26074;
    rst_n       = 1'b0;
    req_valid   = 1'b0;
    req_write   = 1'b0;
    address     = '0;
    data        = '0;
    exp_hit     = 1'b0;
    exp_q       = '0;
    exp_q_known = 1'b0;
    exp_lat     = 0;
    exp_wb      = 1'b0;
    exp_wb_addr = '0;
    exp_wb_data = '0;
    for (int s = 0; s < cache_geom_pkg::num_sets; s++) begin
      m_valid[0][s] = 1'b0;
      m_valid[1][s] = 1'b0;
      m_lru[s]      = 1'b0;
    end
    for (int a = 0; a < cache_geom_pkg::mem_words; a++) begin
      mem_known[a] = 1'b0;  // memory has no reset
    end
    repeat (reset_len) @(posedge clock);
    rst_n <= 1'b1;
    @(posedge clock);

    run_request(1'b1, 5'b001_01, 3'd5);  // tag 1 into way 0 of set 1
    end_test("write miss allocates");
    run_request(1'b0, 5'b001_01, 3'd0);
    end_test("read hit");
    run_request(1'b1, 5'b010_01, 3'd3);  // tag 2 into way 1
    run_request(1'b0, 5'b001_01, 3'd0);  // way 1 becomes lru
    run_request(1'b1, 5'b011_01, 3'd6);  // evicts dirty tag 2
    end_test("lru eviction with writeback");
    run_request(1'b0, 5'b010_01, 3'd0);  // evicts tag 1, reloads tag 2
    end_test("writeback and refill round trip");
    for (int n = 0; n < num_random; n++) begin
      rnd = $random(seed);
      run_request(rnd[8], rnd[4:0], rnd[7:5]);
    end
    end_test("random traffic");

    $display("%0d tests, %0d requests, %0d errors",
             tests_done, req_count, check_errors + flow_errors);
    if (check_errors + flow_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #(watchdog_cycles * period);
    $display("watchdog expired at %0t ns before the tests completed", $time);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- cache_2way.f
logic/cache_geom_pkg.sv
logic/cache_fsm_pkg.sv
logic/cache_array.sv
logic/cache_ctrl.sv
logic/main_mem.sv
logic/cache_2way.sv
dv/cache_2way_tb.sv

//--- run.sh
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=cache_2way_tb
log=sim.log

verilator --binary --timing --assert --top-module "$top" -Mdir obj_dir -f cache_2way.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/V"$top" > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

# the testbench prints its verdict on a line of its own
if grep -qx "Test passed" "$log"; then
  exit 0
fi
echo "pass message not found in $log"
exit 1
